//--- design/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic               clk,
    input  logic               rst,
    input  logic               instrValid,
    input  decodePkg::word_t   instruction,
    output logic               ctrlValid,
    output logic               aluSrc,
    output logic               regDst,
    output logic               regWrite,
    output logic               memRead,
    output logic               memWrite,
    output logic               memToReg,
    output logic               aluSft,
    output logic               zeroSrc,
    output logic               branch,
    output decodePkg::aluOp_t  aluOp
);

    //////////////////////////////
    // field split and decoders
    //////////////////////////////

    instrFieldsIf fieldBus ();

    decodePkg::ctrlWord_t specCtrl;
    decodePkg::ctrlWord_t immCtrl;
    decodePkg::ctrlWord_t multCtrl;
    logic                 specHit;
    logic                 immHit;
    logic                 multHit;

    assign fieldBus.opcode   = decodePkg::opcode_t'(instruction[31:26]);
    assign fieldBus.rt       = instruction[20:16];
    assign fieldBus.sa       = instruction[10:6];
    assign fieldBus.funct    = instruction[5:0];
    assign fieldBus.rotBit21 = instruction[21];

    specialDecoder specDec (
        .fields (fieldBus),
        .ctrl   (specCtrl),
        .hit    (specHit)
    );

    immDecoder immDec (
        .fields (fieldBus),
        .ctrl   (immCtrl),
        .hit    (immHit)
    );

    multExtDecoder multDec (
        .fields (fieldBus),
        .ctrl   (multCtrl),
        .hit    (multHit)
    );

    //////////////////////////////
    // select and register
    //////////////////////////////

    decodePkg::ctrlWord_t nextCtrl;
    decodePkg::ctrlWord_t ctrlReg;

    // decoders own disjoint opcodes, so at most one hits
    always_comb begin
        if (instruction == '0) begin
            // nop would otherwise look like sll
            nextCtrl = decodePkg::CTRL_NONE;
        end else if (specHit) begin
            nextCtrl = specCtrl;
        end else if (immHit) begin
            nextCtrl = immCtrl;
        end else if (multHit) begin
            nextCtrl = multCtrl;
        end else begin
            nextCtrl = decodePkg::CTRL_NONE;
        end
    end

    // outputs hold through idle cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrlValid <= 1'b0;
            ctrlReg   <= decodePkg::CTRL_NONE;
        end else begin
            ctrlValid <= instrValid;
            if (instrValid) begin
                ctrlReg <= nextCtrl;
            end
        end
    end

    assign aluSrc   = ctrlReg.aluSrc;
    assign regDst   = ctrlReg.regDst;
    assign regWrite = ctrlReg.regWrite;
    assign memRead  = ctrlReg.memRead;
    assign memWrite = ctrlReg.memWrite;
    assign memToReg = ctrlReg.memToReg;
    assign aluSft   = ctrlReg.aluSft;
    assign zeroSrc  = ctrlReg.zeroSrc;
    assign branch   = ctrlReg.branch;
    assign aluOp    = ctrlReg.aluOp;

endmodule

//--- design/decodePkg.sv
package decodePkg;

    //////////////////////////////
    // instruction word and fields
    //////////////////////////////

    typedef logic [31:0] word_t;

    // primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        SPECIAL  = 6'b000000,
        REGIMM   = 6'b000001,
        ADDI     = 6'b001000,
        ADDIU    = 6'b001001,
        SLTI     = 6'b001010,
        SLTIU    = 6'b001011,
        ANDI     = 6'b001100,
        ORI      = 6'b001101,
        XORI     = 6'b001110,
        SPECIAL2 = 6'b011100,
        SPECIAL3 = 6'b011111,
        LB       = 6'b100000,
        LH       = 6'b100001,
        LW       = 6'b100011,
        SB       = 6'b101000,
        SH       = 6'b101001,
        SW       = 6'b101011
    } opcode_t;

    // funct codes overlap between SPECIAL and SPECIAL2, so plain constants
    typedef logic [5:0] funct_t;

    // opcode SPECIAL
    localparam funct_t FUNCT_SLL   = 6'b000000;
    localparam funct_t FUNCT_SRL   = 6'b000010;
    localparam funct_t FUNCT_SRA   = 6'b000011;
    localparam funct_t FUNCT_SLLV  = 6'b000100;
    localparam funct_t FUNCT_SRLV  = 6'b000110;
    localparam funct_t FUNCT_SRAV  = 6'b000111;
    localparam funct_t FUNCT_JR    = 6'b001000;
    localparam funct_t FUNCT_MOVZ  = 6'b001010;
    localparam funct_t FUNCT_MOVN  = 6'b001011;
    localparam funct_t FUNCT_MFHI  = 6'b010000;
    localparam funct_t FUNCT_MTHI  = 6'b010001;
    localparam funct_t FUNCT_MFLO  = 6'b010010;
    localparam funct_t FUNCT_MTLO  = 6'b010011;
    localparam funct_t FUNCT_MULT  = 6'b011000;
    localparam funct_t FUNCT_MULTU = 6'b011001;
    localparam funct_t FUNCT_ADD   = 6'b100000;
    localparam funct_t FUNCT_ADDU  = 6'b100001;
    localparam funct_t FUNCT_SUB   = 6'b100010;
    localparam funct_t FUNCT_AND   = 6'b100100;
    localparam funct_t FUNCT_OR    = 6'b100101;
    localparam funct_t FUNCT_XOR   = 6'b100110;
    localparam funct_t FUNCT_NOR   = 6'b100111;
    localparam funct_t FUNCT_SLT   = 6'b101010;
    localparam funct_t FUNCT_SLTU  = 6'b101011;

    // opcode SPECIAL2
    localparam funct_t FUNCT_MADD  = 6'b000000;
    localparam funct_t FUNCT_MUL   = 6'b000010;
    localparam funct_t FUNCT_MSUB  = 6'b000100;

    // rt selects the REGIMM branch
    localparam logic [4:0] REGIMM_BLTZ = 5'b00000;
    localparam logic [4:0] REGIMM_BGEZ = 5'b00001;

    //////////////////////////////
    // execute stage control
    //////////////////////////////

    // codes as the ALU expects them
    typedef enum logic [5:0] {
        ADD   = 6'b000000,
        SUB   = 6'b000001,
        MUL   = 6'b000010,
        MULT  = 6'b000011,
        MADD  = 6'b000100,
        MSUB  = 6'b000101,
        BGEZ  = 6'b000111,
        BLTZ  = 6'b001100,
        AND   = 6'b001111,
        OR    = 6'b010000,
        NOR   = 6'b010001,
        XOR   = 6'b010010,
        SEH   = 6'b010011,
        SLL   = 6'b010100,
        SRL   = 6'b010101,
        MOVN  = 6'b010110,
        MOVZ  = 6'b010111,
        ROTR  = 6'b011000,
        SRA   = 6'b011001,
        SEB   = 6'b011010,
        SLT   = 6'b011011,
        MTHI  = 6'b011100,
        MTLO  = 6'b011101,
        MFHI  = 6'b011110,
        MFLO  = 6'b011111,
        ADDU  = 6'b100000,
        MULTU = 6'b100001,
        SLTU  = 6'b100010,
        JR    = 6'b100011
    } aluOp_t;

    typedef struct packed {
        logic   aluSrc;
        logic   regDst;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   aluSft;
        logic   zeroSrc;
        logic   branch;
        aluOp_t aluOp;
    } ctrlWord_t;

    // bubble, nothing written and nothing taken
    localparam ctrlWord_t CTRL_NONE = '0;

endpackage

//--- design/immDecoder.sv
`timescale 1ns/1ps

module immDecoder (
    instrFieldsIf.sink             fields,
    output decodePkg::ctrlWord_t   ctrl,
    output logic                   hit
);

    // instruction groups within the immediate class
    logic isAluImm;
    logic isLoad;
    logic isStore;

    always_comb begin
        ctrl     = decodePkg::CTRL_NONE;
        hit      = 1'b1;
        isAluImm = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;

        case (fields.opcode)
            // ALU with immediate operand
            decodePkg::ADDI: begin
                ctrl.aluOp = decodePkg::ADD;
                isAluImm   = 1'b1;
            end
            decodePkg::ADDIU: begin
                ctrl.aluOp = decodePkg::ADDU;
                isAluImm   = 1'b1;
            end
            decodePkg::SLTI: begin
                ctrl.aluOp = decodePkg::SLT;
                isAluImm   = 1'b1;
            end
            // zero extended immediates
            decodePkg::ANDI: begin
                ctrl.aluOp   = decodePkg::AND;
                ctrl.zeroSrc = 1'b1;
                isAluImm     = 1'b1;
            end
            decodePkg::ORI: begin
                ctrl.aluOp   = decodePkg::OR;
                ctrl.zeroSrc = 1'b1;
                isAluImm     = 1'b1;
            end
            decodePkg::XORI: begin
                ctrl.aluOp   = decodePkg::XOR;
                ctrl.zeroSrc = 1'b1;
                isAluImm     = 1'b1;
            end
            decodePkg::SLTIU: begin
                ctrl.aluOp   = decodePkg::SLTU;
                ctrl.zeroSrc = 1'b1;
                isAluImm     = 1'b1;
            end

            // address is base plus offset
            decodePkg::LW, decodePkg::LH, decodePkg::LB: isLoad = 1'b1;
            decodePkg::SW, decodePkg::SH, decodePkg::SB: isStore = 1'b1;

            // rt picks the branch condition
            decodePkg::REGIMM: begin
                ctrl.branch = 1'b1;
                if (fields.rt == decodePkg::REGIMM_BGEZ) begin
                    ctrl.aluOp = decodePkg::BGEZ;
                end else if (fields.rt == decodePkg::REGIMM_BLTZ) begin
                    ctrl.aluOp = decodePkg::BLTZ;
                end else begin
                    hit = 1'b0;
                end
            end

            default: hit = 1'b0;
        endcase

        ctrl.aluSrc   = isAluImm | isLoad | isStore;
        ctrl.regWrite = isAluImm | isLoad;
        ctrl.memToReg = isAluImm;
        ctrl.memRead  = isLoad;
        ctrl.memWrite = isStore;
    end

endmodule

//--- design/instrFieldsIf.sv
`timescale 1ns/1ps

interface instrFieldsIf;

    decodePkg::opcode_t opcode;
    logic [4:0]         rt;
    // shamt field, also holds bit 6 (rotrv) and bit 9 (seh)
    logic [4:0]         sa;
    decodePkg::funct_t  funct;
    // R bit of srl/rotr
    logic               rotBit21;

    modport source (
        output opcode, rt, sa, funct, rotBit21
    );

    modport sink (
        input opcode, rt, sa, funct, rotBit21
    );

endinterface

//--- design/multExtDecoder.sv
`timescale 1ns/1ps

module multExtDecoder (
    instrFieldsIf.sink             fields,
    output decodePkg::ctrlWord_t   ctrl,
    output logic                   hit
);

    // madd and msub only accumulate into hi/lo
    logic writesRd;

    always_comb begin
        ctrl     = decodePkg::CTRL_NONE;
        hit      = 1'b0;
        writesRd = 1'b1;

        if (fields.opcode == decodePkg::SPECIAL2) begin
            hit = 1'b1;
            case (fields.funct)
                decodePkg::FUNCT_MUL: ctrl.aluOp = decodePkg::MUL;
                decodePkg::FUNCT_MADD: begin
                    ctrl.aluOp = decodePkg::MADD;
                    writesRd   = 1'b0;
                end
                decodePkg::FUNCT_MSUB: begin
                    ctrl.aluOp = decodePkg::MSUB;
                    writesRd   = 1'b0;
                end
                default: hit = 1'b0;
            endcase
        end else if (fields.opcode == decodePkg::SPECIAL3) begin
            // instruction bit 9 set for seh
            hit        = 1'b1;
            ctrl.aluOp = fields.sa[3] ? decodePkg::SEH : decodePkg::SEB;
        end

        ctrl.regWrite = hit & writesRd;
        ctrl.regDst   = hit & writesRd;
        ctrl.memToReg = hit & writesRd;
    end

endmodule

//--- design/specialDecoder.sv
`timescale 1ns/1ps

module specialDecoder (
    instrFieldsIf.sink             fields,
    output decodePkg::ctrlWord_t   ctrl,
    output logic                   hit
);

    // cleared for the few specials that leave rd alone
    logic writesRd;

    always_comb begin
        ctrl     = decodePkg::CTRL_NONE;
        hit      = 1'b0;
        writesRd = 1'b1;

        if (fields.opcode == decodePkg::SPECIAL) begin
            hit = 1'b1;
            case (fields.funct)
                // shifts by shamt
                decodePkg::FUNCT_SLL: begin
                    ctrl.aluOp  = decodePkg::SLL;
                    ctrl.aluSft = 1'b1;
                end
                decodePkg::FUNCT_SRL: begin
                    ctrl.aluOp  = fields.rotBit21 ? decodePkg::ROTR : decodePkg::SRL;
                    ctrl.aluSft = 1'b1;
                end
                decodePkg::FUNCT_SRA: begin
                    ctrl.aluOp  = decodePkg::SRA;
                    ctrl.aluSft = 1'b1;
                end

                // shifts by register, bit 6 marks rotrv
                decodePkg::FUNCT_SLLV: ctrl.aluOp = decodePkg::SLL;
                decodePkg::FUNCT_SRLV: begin
                    ctrl.aluOp = fields.sa[0] ? decodePkg::ROTR : decodePkg::SRL;
                end
                decodePkg::FUNCT_SRAV: ctrl.aluOp = decodePkg::SRA;

                // arithmetic and logic
                decodePkg::FUNCT_ADD:  ctrl.aluOp = decodePkg::ADD;
                decodePkg::FUNCT_ADDU: ctrl.aluOp = decodePkg::ADDU;
                decodePkg::FUNCT_SUB:  ctrl.aluOp = decodePkg::SUB;
                decodePkg::FUNCT_AND:  ctrl.aluOp = decodePkg::AND;
                decodePkg::FUNCT_OR:   ctrl.aluOp = decodePkg::OR;
                decodePkg::FUNCT_NOR:  ctrl.aluOp = decodePkg::NOR;
                decodePkg::FUNCT_XOR:  ctrl.aluOp = decodePkg::XOR;
                decodePkg::FUNCT_SLT:  ctrl.aluOp = decodePkg::SLT;
                decodePkg::FUNCT_SLTU: ctrl.aluOp = decodePkg::SLTU;
                decodePkg::FUNCT_MOVN: ctrl.aluOp = decodePkg::MOVN;
                decodePkg::FUNCT_MOVZ: ctrl.aluOp = decodePkg::MOVZ;

                // hi/lo unit, results go to hi/lo only
                decodePkg::FUNCT_MULT: begin
                    ctrl.aluOp = decodePkg::MULT;
                    writesRd   = 1'b0;
                end
                decodePkg::FUNCT_MULTU: begin
                    ctrl.aluOp = decodePkg::MULTU;
                    writesRd   = 1'b0;
                end
                decodePkg::FUNCT_MTHI: begin
                    ctrl.aluOp = decodePkg::MTHI;
                    writesRd   = 1'b0;
                end
                decodePkg::FUNCT_MTLO: begin
                    ctrl.aluOp = decodePkg::MTLO;
                    writesRd   = 1'b0;
                end
                decodePkg::FUNCT_MFHI: ctrl.aluOp = decodePkg::MFHI;
                decodePkg::FUNCT_MFLO: ctrl.aluOp = decodePkg::MFLO;

                // register jump
                decodePkg::FUNCT_JR: begin
                    ctrl.aluOp  = decodePkg::JR;
                    ctrl.branch = 1'b1;
                    writesRd    = 1'b0;
                end

                default: hit = 1'b0;
            endcase
        end

        // every writer here targets rd and takes the ALU result
        ctrl.regWrite = hit & writesRd;
        ctrl.regDst   = hit & writesRd;
        ctrl.memToReg = hit & writesRd;
    end

endmodule

//--- files.f
+incdir+verification
design/decodePkg.sv
design/instrFieldsIf.sv
design/specialDecoder.sv
design/immDecoder.sv
design/multExtDecoder.sv
design/controlUnit.sv
verification/tbControlUnit.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module tbControlUnit -o simControlUnit
status=0
output=$(./obj_dir/simControlUnit 2>&1) || status=$?
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
echo "simulation failed, exit status $status"
exit 1

//--- verification/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// control word the execute stage should see for one instruction word
function automatic decodePkg::ctrlWord_t expectCtrl(decodePkg::word_t instr);
    decodePkg::ctrlWord_t want;
    logic [5:0]           op;
    logic [5:0]           fn;
    logic                 known;
    logic                 rClass;
    logic                 shamtShift;
    logic                 isLoad;
    logic                 isStore;
    logic                 isBranch;
    logic                 noWrite;

    want       = decodePkg::CTRL_NONE;
    op         = instr[31:26];
    fn         = instr[5:0];
    known      = 1'b1;
    rClass     = 1'b0;
    shamtShift = 1'b0;
    isLoad     = 1'b0;
    isStore    = 1'b0;
    isBranch   = 1'b0;
    noWrite    = 1'b0;

    case (op)
        decodePkg::SPECIAL: begin
            rClass     = 1'b1;
            shamtShift = fn inside {decodePkg::FUNCT_SLL, decodePkg::FUNCT_SRL,
                                    decodePkg::FUNCT_SRA};
            noWrite    = fn inside {decodePkg::FUNCT_MULT, decodePkg::FUNCT_MULTU,
                                    decodePkg::FUNCT_MTHI, decodePkg::FUNCT_MTLO,
                                    decodePkg::FUNCT_JR};
            isBranch   = (fn == decodePkg::FUNCT_JR);
            case (fn)
                decodePkg::FUNCT_SLL, decodePkg::FUNCT_SLLV: want.aluOp = decodePkg::SLL;
                decodePkg::FUNCT_SRA, decodePkg::FUNCT_SRAV: want.aluOp = decodePkg::SRA;
                // R bit sits at 21 for the shamt form, at 6 for the variable form
                decodePkg::FUNCT_SRL:   want.aluOp = instr[21] ? decodePkg::ROTR : decodePkg::SRL;
                decodePkg::FUNCT_SRLV:  want.aluOp = instr[6] ? decodePkg::ROTR : decodePkg::SRL;
                decodePkg::FUNCT_ADD:   want.aluOp = decodePkg::ADD;
                decodePkg::FUNCT_ADDU:  want.aluOp = decodePkg::ADDU;
                decodePkg::FUNCT_SUB:   want.aluOp = decodePkg::SUB;
                decodePkg::FUNCT_AND:   want.aluOp = decodePkg::AND;
                decodePkg::FUNCT_OR:    want.aluOp = decodePkg::OR;
                decodePkg::FUNCT_NOR:   want.aluOp = decodePkg::NOR;
                decodePkg::FUNCT_XOR:   want.aluOp = decodePkg::XOR;
                decodePkg::FUNCT_SLT:   want.aluOp = decodePkg::SLT;
                decodePkg::FUNCT_SLTU:  want.aluOp = decodePkg::SLTU;
                decodePkg::FUNCT_MOVN:  want.aluOp = decodePkg::MOVN;
                decodePkg::FUNCT_MOVZ:  want.aluOp = decodePkg::MOVZ;
                decodePkg::FUNCT_MULT:  want.aluOp = decodePkg::MULT;
                decodePkg::FUNCT_MULTU: want.aluOp = decodePkg::MULTU;
                decodePkg::FUNCT_MTHI:  want.aluOp = decodePkg::MTHI;
                decodePkg::FUNCT_MTLO:  want.aluOp = decodePkg::MTLO;
                decodePkg::FUNCT_MFHI:  want.aluOp = decodePkg::MFHI;
                decodePkg::FUNCT_MFLO:  want.aluOp = decodePkg::MFLO;
                decodePkg::FUNCT_JR:    want.aluOp = decodePkg::JR;
                default:                known = 1'b0;
            endcase
        end
        decodePkg::SPECIAL2: begin
            rClass  = 1'b1;
            noWrite = (fn != decodePkg::FUNCT_MUL);
            case (fn)
                decodePkg::FUNCT_MUL:  want.aluOp = decodePkg::MUL;
                decodePkg::FUNCT_MADD: want.aluOp = decodePkg::MADD;
                decodePkg::FUNCT_MSUB: want.aluOp = decodePkg::MSUB;
                default:               known = 1'b0;
            endcase
        end
        decodePkg::SPECIAL3: begin
            rClass     = 1'b1;
            want.aluOp = instr[9] ? decodePkg::SEH : decodePkg::SEB;
        end
        decodePkg::REGIMM: begin
            isBranch = 1'b1;
            noWrite  = 1'b1;
            if (instr[20:16] == decodePkg::REGIMM_BGEZ) begin
                want.aluOp = decodePkg::BGEZ;
            end else if (instr[20:16] == decodePkg::REGIMM_BLTZ) begin
                want.aluOp = decodePkg::BLTZ;
            end else begin
                known = 1'b0;
            end
        end
        decodePkg::ADDI:  want.aluOp = decodePkg::ADD;
        decodePkg::ADDIU: want.aluOp = decodePkg::ADDU;
        decodePkg::SLTI:  want.aluOp = decodePkg::SLT;
        decodePkg::ANDI:  want.aluOp = decodePkg::AND;
        decodePkg::ORI:   want.aluOp = decodePkg::OR;
        decodePkg::XORI:  want.aluOp = decodePkg::XOR;
        decodePkg::SLTIU: want.aluOp = decodePkg::SLTU;
        decodePkg::LW, decodePkg::LH, decodePkg::LB: isLoad = 1'b1;
        decodePkg::SW, decodePkg::SH, decodePkg::SB: begin
            isStore = 1'b1;
            noWrite = 1'b1;
        end
        default: known = 1'b0;
    endcase

    // nop and unclaimed words give a bubble
    if (!known || instr == '0) begin
        return decodePkg::CTRL_NONE;
    end

    want.aluSrc   = !rClass && !isBranch;
    want.regWrite = !noWrite;
    want.regDst   = rClass && !noWrite;
    want.memToReg = !noWrite && !isLoad;
    want.memRead  = isLoad;
    want.memWrite = isStore;
    want.aluSft   = shamtShift;
    want.zeroSrc  = op inside {decodePkg::ANDI, decodePkg::ORI, decodePkg::XORI,
                               decodePkg::SLTIU};
    want.branch   = isBranch;
    return want;
endfunction

`endif

//--- verification/tbControlUnit.sv
`timescale 1ns/1ps

module tbControlUnit;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 instrValid;
    decodePkg::word_t     instruction;
    logic                 ctrlValid;
    logic                 aluSrc, regDst, regWrite, memRead, memWrite;
    logic                 memToReg, aluSft, zeroSrc, branch;
    decodePkg::aluOp_t    aluOp;

    // instructions still waiting for their control word
    decodePkg::word_t     sentQ[$];
    decodePkg::ctrlWord_t heldCtrl = decodePkg::CTRL_NONE;
    logic                 lastValid = 1'b0;
    logic                 lastRst = 1'b1;
    int                   resultCount = 0;

    localparam decodePkg::funct_t SPEC_FUNCTS [24] = '{
        decodePkg::FUNCT_SLL, decodePkg::FUNCT_SRL, decodePkg::FUNCT_SRA,
        decodePkg::FUNCT_SLLV, decodePkg::FUNCT_SRLV, decodePkg::FUNCT_SRAV,
        decodePkg::FUNCT_JR, decodePkg::FUNCT_MOVZ, decodePkg::FUNCT_MOVN,
        decodePkg::FUNCT_MFHI, decodePkg::FUNCT_MTHI, decodePkg::FUNCT_MFLO,
        decodePkg::FUNCT_MTLO, decodePkg::FUNCT_MULT, decodePkg::FUNCT_MULTU,
        decodePkg::FUNCT_ADD, decodePkg::FUNCT_ADDU, decodePkg::FUNCT_SUB,
        decodePkg::FUNCT_AND, decodePkg::FUNCT_OR, decodePkg::FUNCT_XOR,
        decodePkg::FUNCT_NOR, decodePkg::FUNCT_SLT, decodePkg::FUNCT_SLTU
    };
    localparam logic [5:0] IMM_OPS [13] = '{
        decodePkg::ADDI, decodePkg::ADDIU, decodePkg::SLTI, decodePkg::SLTIU,
        decodePkg::ANDI, decodePkg::ORI, decodePkg::XORI, decodePkg::LW,
        decodePkg::LH, decodePkg::LB, decodePkg::SW, decodePkg::SH, decodePkg::SB
    };
    localparam decodePkg::funct_t MUL2_FUNCTS [3] = '{
        decodePkg::FUNCT_MUL, decodePkg::FUNCT_MADD, decodePkg::FUNCT_MSUB
    };
    // codes that no decoder claims
    localparam logic [5:0] FREE_OPS [8] = '{6'h02, 6'h03, 6'h04, 6'h07, 6'h0f, 6'h22, 6'h2e, 6'h3f};
    localparam logic [5:0] FREE_SPEC [6] = '{6'h01, 6'h05, 6'h0c, 6'h1a, 6'h28, 6'h3f};
    localparam logic [5:0] FREE_SPEC2 [4] = '{6'h01, 6'h03, 6'h20, 6'h3f};

    `include "refModel.svh"

    controlUnit uut (.*);

    always #2 clk = ~clk;

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic checkCtrl(decodePkg::ctrlWord_t actual, decodePkg::ctrlWord_t expected,
                             decodePkg::word_t instr);
        if (actual !== expected) begin
            abortRun($sformatf(
                "MISMATCH at %0t: instruction %08h gives %04h (%s), expected %04h (%s)",
                $time, instr, actual, actual.aluOp.name(), expected, expected.aluOp.name()));
        end
    endtask

    task automatic checkValid(logic actual, logic expected);
        if (actual !== expected) begin
            abortRun($sformatf("MISMATCH at %0t: ctrlValid is %b, expected %b",
                               $time, actual, expected));
        end
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        decodePkg::ctrlWord_t actual;
        decodePkg::word_t     sent;

        actual = {aluSrc, regDst, regWrite, memRead, memWrite, memToReg, aluSft,
                  zeroSrc, branch, aluOp};
        checkValid(ctrlValid, lastValid);
        if (lastRst) begin
            checkCtrl(actual, decodePkg::CTRL_NONE, '0);
            heldCtrl = decodePkg::CTRL_NONE;
        end else if (ctrlValid) begin
            if (sentQ.size() == 0) begin
                abortRun("ctrlValid went high with no instruction outstanding");
            end else begin
                sent = sentQ.pop_front();
                heldCtrl = expectCtrl(sent);
                checkCtrl(actual, heldCtrl, sent);
                resultCount++;
            end
        end else begin
            // idle cycle keeps the last word
            checkCtrl(actual, heldCtrl, instruction);
        end
        lastValid = instrValid & ~rst;
        lastRst   = rst;
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    function automatic decodePkg::word_t fieldWord(logic [5:0] op, logic [5:0] fn);
        decodePkg::word_t r;

        r = $urandom;
        return {op, r[25:6], fn};
    endfunction

    function automatic decodePkg::word_t regimmWord(logic [4:0] rt);
        decodePkg::word_t w;

        w = fieldWord(decodePkg::REGIMM, 6'($urandom));
        w[20:16] = rt;
        return w;
    endfunction

    function automatic decodePkg::word_t randomTrafficWord();
        int idx;

        idx = $urandom_range(0, 23);
        case ($urandom_range(0, 4))
            0: return fieldWord(decodePkg::SPECIAL, SPEC_FUNCTS[idx]);
            1: return fieldWord(IMM_OPS[idx % 13], 6'($urandom));
            2: return fieldWord(decodePkg::SPECIAL2, MUL2_FUNCTS[idx % 3]);
            3: return regimmWord(5'($urandom_range(0, 1)));
            default: return $urandom;
        endcase
    endfunction

    task automatic sendInstr(decodePkg::word_t w);
        @(posedge clk);
        instrValid  <= 1'b1;
        instruction <= w;
        sentQ.push_back(w);
    endtask

    task automatic idleCycles(int n);
        repeat (n) begin
            @(posedge clk);
            instrValid  <= 1'b0;
            instruction <= $urandom;
        end
    endtask

    // same word with one bit low, then high
    task automatic sendPair(decodePkg::word_t w, int bitPos);
        w[bitPos] = 1'b0;
        sendInstr(w);
        w[bitPos] = 1'b1;
        sendInstr(w);
    endtask

    initial begin
        int waitCycles;
        decodePkg::word_t w;

        rst         = 1'b1;
        instrValid  = 1'b0;
        instruction = '0;
        void'($urandom(32'h152cba1d));
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        idleCycles(2);

        // sweep of every decoded instruction
        for (int i = 0; i < $size(SPEC_FUNCTS); i++) begin
            repeat (3) sendInstr(fieldWord(decodePkg::SPECIAL, SPEC_FUNCTS[i]));
        end
        for (int i = 0; i < $size(IMM_OPS); i++) begin
            repeat (3) sendInstr(fieldWord(IMM_OPS[i], 6'($urandom)));
        end
        for (int i = 0; i < $size(MUL2_FUNCTS); i++) begin
            repeat (3) sendInstr(fieldWord(decodePkg::SPECIAL2, MUL2_FUNCTS[i]));
        end
        repeat (3) sendInstr(fieldWord(decodePkg::SPECIAL3, 6'($urandom)));
        sendInstr(regimmWord(decodePkg::REGIMM_BGEZ));
        sendInstr(regimmWord(decodePkg::REGIMM_BLTZ));
        idleCycles(1);

        // pairs that differ in a single bit
        repeat (4) begin
            sendPair(fieldWord(decodePkg::SPECIAL, decodePkg::FUNCT_SRL), 21);
            sendPair(fieldWord(decodePkg::SPECIAL, decodePkg::FUNCT_SRLV), 6);
            sendPair(fieldWord(decodePkg::SPECIAL3, 6'($urandom)), 9);
            sendPair(regimmWord(decodePkg::REGIMM_BLTZ), 16);
        end

        // nop and unclaimed encodings
        sendInstr('0);
        for (int i = 0; i < $size(FREE_OPS); i++) begin
            sendInstr(fieldWord(FREE_OPS[i], 6'($urandom)));
        end
        for (int i = 0; i < $size(FREE_SPEC); i++) begin
            sendInstr(fieldWord(decodePkg::SPECIAL, FREE_SPEC[i]));
        end
        for (int i = 0; i < $size(FREE_SPEC2); i++) begin
            sendInstr(fieldWord(decodePkg::SPECIAL2, FREE_SPEC2[i]));
        end
        repeat (6) begin
            w = regimmWord(5'($urandom_range(2, 31)));
            sendInstr(w);
        end

        // back to back traffic with random gaps
        repeat (300) begin
            sendInstr(randomTrafficWord());
            if ($urandom_range(0, 3) == 0) begin
                idleCycles($urandom_range(1, 3));
            end
        end
        idleCycles(1);

        // pops happen on the falling edge, so look between them
        for (waitCycles = 0; waitCycles < 20 && sentQ.size() != 0; waitCycles++) begin
            @(posedge clk);
        end
        if (sentQ.size() != 0) begin
            abortRun("timed out waiting for control words of outstanding instructions");
        end else begin
            $display("%0d control words checked", resultCount);
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule
